/* build.f */
+incdir+source
+incdir+bench
source/corePkg.sv
source/pipeReg.sv
source/instnDecode.sv
source/regFile.sv
source/execUnit.sv
source/hazardUnit.sv
source/riscvCore.sv
bench/coreTb.sv

/* Makefile */
# build and run the core testbench with Verilator

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module coreTb \
		-f build.f -Mdir obj_dir -o coreSim
	./obj_dir/coreSim

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bench/coreTests.svh */
/* directed programs for the core, each built with the small assembler below
   a test loads its program, runs it to the done store and checks every store */

	// funct7 and funct3 of the register ALU ops
	localparam logic [9:0] fnAdd = 10'b0000000_000;
	localparam logic [9:0] fnSub = 10'b0100000_000;
	localparam logic [9:0] fnAnd = 10'b0000000_111;
	localparam logic [9:0] fnOr = 10'b0000000_110;
	localparam logic [9:0] fnXor = 10'b0000000_100;
	localparam logic [9:0] fnSlt = 10'b0000000_010;

	function automatic logic [31:0] regOp(input logic [9:0] fn, input int rd,
			input int rs1, input int rs2);
		return {fn[9:3], 5'(rs2), 5'(rs1), fn[2:0], 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] addImm(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
	endfunction

	function automatic logic [31:0] loadUpper(input int rd, input int upper);
		return {20'(upper), 5'(rd), 7'b0110111};
	endfunction

	function automatic logic [31:0] loadWord(input int rd, input int rs1, input int off);
		return {12'(off), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
	endfunction

	function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int off);
		logic [11:0] o;
		o = 12'(off);
		return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], 7'b0100011};
	endfunction

	// ne high gives BNE
	function automatic logic [31:0] branchIf(input logic ne, input int rs1, input int rs2,
			input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jumpLink(input int rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic logic [`XLEN-1:0] signExt(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	task automatic emit(input logic [31:0] instn);
		prog.push_back(instn);
	endtask

	// sw rs2 to an absolute address, plus the store it must produce
	task automatic emitStore(input int rs2, input int addr, input logic [`XLEN-1:0] value);
		prog.push_back(storeWord(rs2, 0, addr));
		expected.push_back('{addr: 32'(addr), data: value});
	endtask

	task automatic startProgram(input string name);
		testName = name;
		prog.delete();
		expected.delete();
	endtask

	task automatic beginRun();
		// done marker, then jump to self
		prog.push_back(storeWord(0, 0, int'(doneAddr)));
		prog.push_back(jumpLink(0, 0));
		budget += prog.size() + 16;
		@(posedge clk);
		#1;
		arstN = 1'b0;
		loadProgram();
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
	endtask

	task automatic finishRun();
		while (!programDone) @(negedge clk);
		compareStores();
	endtask

	task automatic runProgram();
		beginRun();
		finishRun();
	endtask

	task automatic aluImmTest();
		logic [11:0] immA, immB, immC;
		logic [19:0] upper;
		logic [`XLEN-1:0] a, b, c, u;
		immA = 12'($random(seed));
		immB = 12'($random(seed));
		immC = 12'($random(seed));
		upper = 20'($random(seed));
		a = signExt(immA);
		b = signExt(immB);
		c = signExt(immC);
		u = {upper, 12'h000};
		startProgram("aluImmTest");
		emit(addImm(1, 0, int'(immA)));
		emit(addImm(2, 0, int'(immB)));
		emit(loadUpper(3, int'(upper)));
		emit(regOp(fnAdd, 4, 1, 2));
		emitStore(4, 'h400, a + b);
		emit(regOp(fnSub, 5, 1, 2));
		emitStore(5, 'h404, a - b);
		emit(regOp(fnAnd, 6, 1, 2));
		emitStore(6, 'h408, a & b);
		emit(regOp(fnOr, 7, 1, 2));
		emitStore(7, 'h40C, a | b);
		emit(regOp(fnXor, 8, 1, 2));
		emitStore(8, 'h410, a ^ b);
		// signed compare both ways
		emit(regOp(fnSlt, 9, 1, 2));
		emitStore(9, 'h414, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		emit(regOp(fnSlt, 10, 2, 1));
		emitStore(10, 'h418, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		emitStore(3, 'h41C, u);
		emit(addImm(11, 3, int'(immC)));
		emitStore(11, 'h420, u + c);
		runProgram();
	endtask

	task automatic forwardTest();
		startProgram("forwardTest");
		emit(addImm(1, 0, 5));
		// x1 one ahead, then two ahead
		emit(addImm(2, 1, 7));
		emit(addImm(3, 1, 3));
		// x1 from the register file while it is written, x2 from writeback
		emit(regOp(fnAdd, 4, 1, 2));
		emit(regOp(fnAdd, 5, 4, 4));
		emitStore(5, 'h4A0, 32'd34);
		emitStore(2, 'h4A4, 32'd12);
		emitStore(3, 'h4A8, 32'd8);
		emitStore(4, 'h4AC, 32'd17);
		runProgram();
	endtask

	task automatic loadUseTest();
		logic [11:0] addend;
		addend = 12'($random(seed));
		startProgram("loadUseTest");
		emit(loadWord(1, 0, 'h500));
		emit(addImm(2, 1, int'(addend)));
		emitStore(2, 'h4B0, fillWord('h500 >> 2) + signExt(addend));
		// loaded value straight into store data
		emit(loadWord(3, 0, 'h504));
		emitStore(3, 'h4B4, fillWord('h504 >> 2));
		emit(addImm(4, 0, 'h77));
		emitStore(4, 'h508, 32'h77);
		emit(loadWord(5, 0, 'h508));
		emit(regOp(fnAdd, 6, 5, 5));
		emitStore(6, 'h4B8, 32'hEE);
		runProgram();
	endtask

	task automatic branchTest();
		logic [`XLEN-1:0] linkPc;
		startProgram("branchTest");
		emit(addImm(1, 0, 3));
		emit(addImm(2, 0, 3));
		emit(addImm(3, 0, 9));
		// taken BEQ over two stores
		emit(branchIf(1'b0, 1, 2, 12));
		emit(storeWord(3, 0, 'h460));
		emit(storeWord(3, 0, 'h464));
		emitStore(1, 'h468, 32'd3);
		// not taken BNE and BEQ
		emit(branchIf(1'b1, 1, 2, 8));
		emitStore(2, 'h46C, 32'd3);
		emit(branchIf(1'b0, 1, 3, 8));
		emitStore(3, 'h470, 32'd9);
		// taken BNE
		emit(branchIf(1'b1, 1, 3, 12));
		emit(storeWord(3, 0, 'h474));
		emit(storeWord(3, 0, 'h478));
		linkPc = 32'(prog.size() * 4) + 32'd4;
		emit(jumpLink(5, 12));
		emit(storeWord(3, 0, 'h47C));
		emit(storeWord(3, 0, 'h480));
		emitStore(5, 'h484, linkPc);
		runProgram();
	endtask

	task automatic zeroRegTest();
		startProgram("zeroRegTest");
		emit(addImm(0, 0, 123));
		emit(loadUpper(0, 'hABCDE));
		emitStore(0, 'h490, 32'd0);
		// a write to x0 just ahead must not forward
		emit(addImm(0, 0, 5));
		emit(addImm(3, 0, 1));
		emitStore(3, 'h494, 32'd1);
		emit(regOp(fnAdd, 0, 3, 3));
		emit(regOp(fnAdd, 4, 0, 3));
		emitStore(4, 'h498, 32'd1);
		emitStore(0, 'h49C, 32'd0);
		runProgram();
	endtask

	task automatic resetMidTest();
		startProgram("resetMidTest");
		emit(addImm(1, 0, 11));
		emitStore(1, 'h450, 32'd11);
		emit(addImm(2, 1, 22));
		emitStore(2, 'h454, 32'd33);
		emit(addImm(3, 2, 33));
		emitStore(3, 'h458, 32'd66);
		emit(loadUpper(4, 'h12345));
		emitStore(4, 'h45C, 32'h1234_5000);
		beginRun();
		budget += 16;
		// cut in after the first store
		while (observed.size() == 0) @(negedge clk);
		@(posedge clk);
		#1;
		arstN = 1'b0;
		repeat (5) begin
			@(negedge clk);
			if (dmemWe !== 1'b0) begin
				abortRun("resetMidTest: data write strobe was high while reset was held");
			end
			checkAddr(`RESET_PC, pcImem);
		end
		@(posedge clk);
		#1;
		arstN = 1'b1;
		@(negedge clk);
		checkAddr(`RESET_PC, pcImem);
		// no store can reach memory before the fourth cycle
		repeat (3) begin
			if (dmemWe !== 1'b0) begin
				abortRun("resetMidTest: data write strobe rose before the program restarted");
			end
			@(negedge clk);
		end
		finishRun();
	endtask

/* bench/coreTb.sv */
/* testbench for the pipelined core: clock, reset, instruction and data memories,
   store recorder, watchdog and the compare tasks used by the directed tests */
`timescale 1ns/100ps
`default_nettype none
`include "core_cfg.svh"

module coreTb;

	// one recorded store on the data port
	typedef struct packed {
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] data;
	} storeRecT;

	// ADDI x0, x0, 0
	localparam logic [31:0] nopInstn = 32'h0000_0013;
	// store here marks the end of a program
	localparam logic [`XLEN-1:0] doneAddr = 32'h0000_07FC;

	logic clk;
	logic arstN;
	logic [`XLEN-1:0] pcImem;
	logic [`XLEN-1:0] imemInstn;
	logic dmemWe;
	logic [`XLEN-1:0] dmemAddr;
	logic [`XLEN-1:0] dmemWd;
	logic [`XLEN-1:0] dmemRd;

	logic [31:0] imem [256];
	logic [`XLEN-1:0] dmem [512];
	logic [31:0] prog [$];
	storeRecT expected [$];
	storeRecT observed [$];
	logic programDone;
	string testName;
	int seed = 55;
	int budget = 0;
	int cycleCount = 0;

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	riscvCore i_dut (
		.clk(clk),
		.arstN(arstN),
		.pcImem(pcImem),
		.imemInstn(imemInstn),
		.dmemWe(dmemWe),
		.dmemAddr(dmemAddr),
		.dmemWd(dmemWd),
		.dmemRd(dmemRd)
	);

	// pattern over the whole word index
	function automatic logic [`XLEN-1:0] fillWord(input int idx);
		return (32'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
	endfunction

	// both memories answer in the same cycle
	assign imemInstn = imem[pcImem[9:2]];
	assign dmemRd = dmem[dmemAddr[10:2]];

	// refilled while reset is held, written on the rising edge otherwise
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 512; i++) begin
				dmem[i] <= fillWord(i);
			end
		end else if (dmemWe) begin
			dmem[dmemAddr[10:2]] <= dmemWd;
		end
	end

	// store log, sampled mid cycle
	always @(negedge clk) begin
		if (!arstN) begin
			observed.delete();
			programDone = 1'b0;
		end else if (dmemWe) begin
			if (dmemAddr == doneAddr) begin
				programDone = 1'b1;
			end else begin
				observed.push_back('{addr: dmemAddr, data: dmemWd});
			end
		end
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// budget grows with every program that starts
	initial begin
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount > 4 * budget) begin
				abortRun($sformatf("watchdog expired after %0d cycles in %s",
					cycleCount, testName));
			end
		end
	end

	task automatic checkWord(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
		if (act !== exp) begin
			abortRun($sformatf("[ERROR] %s: data expected %h actual %h", testName, exp, act));
		end
	endtask

	task automatic checkAddr(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
		if (act !== exp) begin
			abortRun($sformatf("[ERROR] %s: address expected %h actual %h",
				testName, exp, act));
		end
	endtask

	// in-order match of the store log against the expected list
	task automatic compareStores();
		int n;
		n = (observed.size() < expected.size()) ? observed.size() : expected.size();
		for (int i = 0; i < n; i++) begin
			if (observed[i] != expected[i]) begin
				for (int j = 0; j < expected.size(); j++) begin
					if (j != i && observed[i] == expected[j]) begin
						abortRun($sformatf("%s: store to %h arrived out of order",
							testName, observed[i].addr));
					end
				end
			end
			checkAddr(expected[i].addr, observed[i].addr);
			checkWord(expected[i].data, observed[i].data);
		end
		if (observed.size() != expected.size()) begin
			abortRun($sformatf("%s: saw %0d stores but expected %0d",
				testName, observed.size(), expected.size()));
		end
	endtask

	// rest of the instruction memory is NOPs
	task automatic loadProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : nopInstn;
		end
	endtask

	`include "coreTests.svh"

	initial begin
		arstN = 1'b0;
		prog.delete();
		loadProgram();
		aluImmTest();
		forwardTest();
		loadUseTest();
		branchTest();
		zeroRegTest();
		resetMidTest();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* source/riscvCore.sv */
/* five-stage in-order RV32I subset core, top level
   combinational instruction port, data port with write strobe in the memory stage */
`timescale 1ns/100ps
`default_nettype none
`include "core_cfg.svh"

module riscvCore import corePkg::*; (
	input logic clk,
	input logic arstN,
	output logic [`XLEN-1:0] pcImem,
	input logic [`XLEN-1:0] imemInstn,
	output logic dmemWe,
	output logic [`XLEN-1:0] dmemAddr,
	output logic [`XLEN-1:0] dmemWd,
	input logic [`XLEN-1:0] dmemRd
);

	localparam logic [`XLEN-1:0] pcStep = 4;

	// fetch
	logic [`XLEN-1:0] pcF;
	fetchDecodeT fdIn, fd;

	// decode
	ctrlT dCtrl;
	logic [`XLEN-1:0] dImm, rs1Val, rs2Val;
	logic [4:0] dRs1, dRs2, dRd;
	decodeExecT dxIn, dx;

	// execute, memory, writeback
	execMemT emIn, em;
	memWbT mwIn, mw;
	logic [`XLEN-1:0] wbResult, targetPc;
	logic redirect;

	// hazard controls
	fwdSelE fwdA, fwdB;
	logic stallF, stallD, flushD, flushE;

	// PC register, redirect from execute beats sequential fetch
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= `RESET_PC;
		end else if (redirect) begin
			pcF <= targetPc;
		end else if (!stallF) begin
			pcF <= pcF + pcStep;
		end
	end

	assign pcImem = pcF;
	assign fdIn = '{pc: pcF, instn: imemInstn};

	pipeReg #(.payloadT(fetchDecodeT)) fdReg (
		.clk(clk), .arstN(arstN),
		.en(!stallD), .clear(flushD),
		.d(fdIn), .q(fd)
	);

	instnDecode decodeUnit (
		.instn(fd.instn),
		.ctrl(dCtrl), .imm(dImm),
		.rs1(dRs1), .rs2(dRs2), .rd(dRd)
	);

	// written from writeback, read in decode
	regFile regs (
		.clk(clk), .arstN(arstN),
		.we(mw.regWrite), .wAddr(mw.rd), .wData(wbResult),
		.rAddrA(dRs1), .rAddrB(dRs2),
		.rDataA(rs1Val), .rDataB(rs2Val)
	);

	assign dxIn = '{ctrl: dCtrl, pc: fd.pc, rs1Val: rs1Val, rs2Val: rs2Val,
		imm: dImm, rs1: dRs1, rs2: dRs2, rd: dRd};

	pipeReg #(.payloadT(decodeExecT)) dxReg (
		.clk(clk), .arstN(arstN),
		.en(1'b1), .clear(flushE),
		.d(dxIn), .q(dx)
	);

	execUnit exec (
		.dx(dx),
		.fwdA(fwdA), .fwdB(fwdB),
		.memAluOut(em.aluOut), .wbResult(wbResult),
		.em(emIn),
		.redirect(redirect), .targetPc(targetPc)
	);

	pipeReg #(.payloadT(execMemT)) emReg (
		.clk(clk), .arstN(arstN),
		.en(1'b1), .clear(1'b0),
		.d(emIn), .q(em)
	);

	// memory stage drives the data port directly
	assign dmemWe = em.memWrite;
	assign dmemAddr = em.aluOut;
	assign dmemWd = em.storeData;

	assign mwIn = '{regWrite: em.regWrite, memToReg: em.memToReg, aluOut: em.aluOut,
		readData: dmemRd, rd: em.rd};

	pipeReg #(.payloadT(memWbT)) mwReg (
		.clk(clk), .arstN(arstN),
		.en(1'b1), .clear(1'b0),
		.d(mwIn), .q(mw)
	);

	// load data or ALU result
	assign wbResult = mw.memToReg ? mw.readData : mw.aluOut;

	hazardUnit hazard (
		.dRs1(dRs1), .dRs2(dRs2),
		.dx(dx), .em(em), .mw(mw),
		.redirect(redirect),
		.fwdA(fwdA), .fwdB(fwdB),
		.stallF(stallF), .stallD(stallD),
		.flushD(flushD), .flushE(flushE)
	);

endmodule : riscvCore

`default_nettype wire

/* source/hazardUnit.sv */
/* pipeline hazard control: execute forwarding selects, load-use stall
   and the decode/execute flush on a redirect */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit import corePkg::*; (
	input logic [4:0] dRs1,
	input logic [4:0] dRs2,
	input decodeExecT dx,
	input execMemT em,
	input memWbT mw,
	input logic redirect,
	output fwdSelE fwdA,
	output fwdSelE fwdB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE
);

	logic loadUse;

	// memory stage wins, x0 never forwards
	function automatic fwdSelE pickSource(input logic [4:0] src, input execMemT memSt,
			input memWbT wbSt);
		fwdSelE sel;
		sel = fwdNone;
		if (src != 5'd0) begin
			if (memSt.regWrite && memSt.rd == src) begin
				sel = fwdMem;
			end else if (wbSt.regWrite && wbSt.rd == src) begin
				sel = fwdWb;
			end
		end
		return sel;
	endfunction

	assign fwdA = pickSource(dx.rs1, em, mw);
	assign fwdB = pickSource(dx.rs2, em, mw);

	// load in execute feeding the instruction in decode
	assign loadUse = dx.ctrl.memToReg && dx.rd != 5'd0
		&& (dx.rd == dRs1 || dx.rd == dRs2);

	// hold fetch and decode, bubble into execute
	assign stallF = loadUse;
	assign stallD = loadUse;

	// taken branch or JAL kills the two younger slots
	assign flushD = redirect;
	assign flushE = redirect | loadUse;

endmodule : hazardUnit

`default_nettype wire

/* source/execUnit.sv */
/* execute stage: forwarded operands, ALU, link value and branch or jump resolution
   redirect and targetPc go back to the PC register */
`timescale 1ns/100ps
`default_nettype none
`include "core_cfg.svh"

module execUnit import corePkg::*; (
	input decodeExecT dx,
	input fwdSelE fwdA,
	input fwdSelE fwdB,
	input logic [`XLEN-1:0] memAluOut,
	input logic [`XLEN-1:0] wbResult,
	output execMemT em,
	output logic redirect,
	output logic [`XLEN-1:0] targetPc
);

	localparam logic [`XLEN-1:0] pcStep = 4;

	logic [`XLEN-1:0] opA, opB, aluB, aluResult;
	logic branchTaken;

	// operand muxes, memory result is younger than writeback
	always_comb begin
		unique case (fwdA)
			fwdMem: opA = memAluOut;
			fwdWb: opA = wbResult;
			default: opA = dx.rs1Val;
		endcase
		unique case (fwdB)
			fwdMem: opB = memAluOut;
			fwdWb: opB = wbResult;
			default: opB = dx.rs2Val;
		endcase
	end

	assign aluB = dx.ctrl.aluSrc ? dx.imm : opB;

	always_comb begin
		unique case (dx.ctrl.aluOp)
			aluSub: aluResult = opA - aluB;
			aluAnd: aluResult = opA & aluB;
			aluOr: aluResult = opA | aluB;
			aluXor: aluResult = opA ^ aluB;
			aluSlt: aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			aluPassB: aluResult = aluB;
			default: aluResult = opA + aluB;
		endcase
	end

	// BEQ on equal, BNE on not equal
	assign branchTaken = dx.ctrl.branch & ((opA == opB) ^ dx.ctrl.branchNe);
	assign redirect = branchTaken | dx.ctrl.jump;
	assign targetPc = dx.pc + dx.imm;

	always_comb begin
		em.regWrite = dx.ctrl.regWrite;
		em.memToReg = dx.ctrl.memToReg;
		em.memWrite = dx.ctrl.memWrite;
		// JAL links pc+4 into rd
		em.aluOut = dx.ctrl.jump ? dx.pc + pcStep : aluResult;
		em.storeData = opB;
		em.rd = dx.rd;
	end

endmodule : execUnit

`default_nettype wire

/* source/regFile.sv */
/* integer register file, two combinational reads and one write per cycle
   a read of the register being written returns the new value */
`timescale 1ns/100ps
`default_nettype none
`include "core_cfg.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic we,
	input logic [4:0] wAddr,
	input logic [`XLEN-1:0] wData,
	input logic [4:0] rAddrA,
	input logic [4:0] rAddrB,
	output logic [`XLEN-1:0] rDataA,
	output logic [`XLEN-1:0] rDataB
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// writes to x0 are dropped
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// x0 first, then write-through from writeback
	always_comb begin
		rDataA = regs[rAddrA];
		if (rAddrA == 5'd0) begin
			rDataA = '0;
		end else if (we && rAddrA == wAddr) begin
			rDataA = wData;
		end
		rDataB = regs[rAddrB];
		if (rAddrB == 5'd0) begin
			rDataB = '0;
		end else if (we && rAddrB == wAddr) begin
			rDataB = wData;
		end
	end

endmodule : regFile

`default_nettype wire

/* source/instnDecode.sv */
/* decode of one instruction: register fields, immediate and controls
   anything outside the supported subset comes out as a no-op */
`timescale 1ns/100ps
`default_nettype none
`include "core_cfg.svh"

module instnDecode import corePkg::*; (
	input logic [`XLEN-1:0] instn,
	output ctrlT ctrl,
	output logic [`XLEN-1:0] imm,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd
);

	opcodeE opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
	logic useRs1, useRs2;

	assign opcode = opcodeE'(instn[6:0]);
	assign funct3 = instn[14:12];
	assign funct7 = instn[31:25];

	// immediate formats, all sign extended from bit 31
	assign immI = {{20{instn[31]}}, instn[31:20]};
	assign immS = {{20{instn[31]}}, instn[31:25], instn[11:7]};
	assign immB = {{19{instn[31]}}, instn[31], instn[7], instn[30:25], instn[11:8], 1'b0};
	assign immU = {instn[31:12], 12'b0};
	assign immJ = {{11{instn[31]}}, instn[31], instn[19:12], instn[20], instn[30:21], 1'b0};

	// unused source fields read as x0 so they never trigger a stall
	assign rs1 = useRs1 ? instn[19:15] : 5'd0;
	assign rs2 = useRs2 ? instn[24:20] : 5'd0;
	assign rd = instn[11:7];

	always_comb begin
		ctrl = '0;
		imm = '0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		unique case (opcode)
			opReg: begin
				ctrl.regWrite = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: ctrl.aluOp = aluAdd;
					10'b0100000_000: ctrl.aluOp = aluSub;
					10'b0000000_111: ctrl.aluOp = aluAnd;
					10'b0000000_110: ctrl.aluOp = aluOr;
					10'b0000000_100: ctrl.aluOp = aluXor;
					10'b0000000_010: ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			opImm: if (funct3 == 3'b000) begin
				// ADDI only
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				imm = immI;
				useRs1 = 1'b1;
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluPassB;
				imm = immU;
			end
			opLoad: if (funct3 == 3'b010) begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				imm = immI;
				useRs1 = 1'b1;
			end
			opStore: if (funct3 == 3'b010) begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				imm = immS;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			opBranch: if (funct3 == 3'b000 || funct3 == 3'b001) begin
				// funct3 bit 0 picks BNE over BEQ
				ctrl.branch = 1'b1;
				ctrl.branchNe = funct3[0];
				imm = immB;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.jump = 1'b1;
				imm = immJ;
			end
			default: ctrl = '0;
		endcase
	end

endmodule : instnDecode

`default_nettype wire

/* source/pipeReg.sv */
/* stage register between two pipeline stages, any payload struct
   en low holds, clear loads a bubble */
`timescale 1ns/100ps
`default_nettype none

module pipeReg import corePkg::*; #(
	parameter type payloadT = fetchDecodeT
) (
	input logic clk,
	input logic arstN,
	input logic en,
	input logic clear,
	input payloadT d,
	output payloadT q
);

	// clear wins over a stall so a flushed slot never survives
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule : pipeReg

`default_nettype wire

/* source/corePkg.sv */
/* opcodes, ALU operations, decoded controls and the payloads between pipeline stages
   pull in with a wildcard import in the module header */
`default_nettype none
`include "core_cfg.svh"

package corePkg;

	// supported RV32I instruction classes
	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLui    = 7'b0110111,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111
	} opcodeE;

	// aluPassB feeds the immediate straight through for LUI
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOpE;

	// all-zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic branch;
		logic branchNe;
		logic jump;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instn;
	} fetchDecodeT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1Val;
		logic [`XLEN-1:0] rs2Val;
		logic [`XLEN-1:0] imm;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
	} decodeExecT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [`XLEN-1:0] aluOut;
		logic [`XLEN-1:0] storeData;
		logic [4:0] rd;
	} execMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [`XLEN-1:0] aluOut;
		logic [`XLEN-1:0] readData;
		logic [4:0] rd;
	} memWbT;

	// operand source in execute
	typedef enum logic [1:0] {
		fwdNone,
		fwdMem,
		fwdWb
	} fwdSelE;

endpackage : corePkg

`default_nettype wire

/* source/core_cfg.svh */
/* build-time constants of the core
   included by the package, the top level and any block sized by the data width */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// data and address width
`define XLEN 32

// architectural register count, x0 included
`define NUM_REGS 32

`endif
